// File: bench/pipeChecker.sv
`default_nettype none
`include "pipe_defines.svh"

module pipeChecker (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [`PIPE_XLEN-1:0] fetchPc,
    input  logic                  fetchReady,
    input  logic                  icacheBusy,
    input  logic                  dcacheBusy,
    input  logic                  retireValid,
    input  pipePkg::retireT       retire,
    output logic                  done,
    output int                    errCount,
    output logic                  timedOut
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IdleLimit = 300;   // cycles without a retire before giving up

    pipePkg::retireT expQ[$];         // expected retires in program order
    pipePkg::retireT head;
    logic            resetSeen  = 1'b0;
    int              retired    = 0;
    int              jumps      = 0;
    int              idle       = 0;
    int              busyCycles = 0;
    int              busyErrs   = 0;
    int              retireErrs = 0;

    initial begin
        done     = 1'b0;
        errCount = 0;
        timedOut = 1'b0;
    end

    // bench pushes one entry per instruction on the interpreted path
    task automatic addExpected(input pipePkg::retireT rec);
        expQ.push_back(rec);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("error %s: got %h expected %h at retire %0d", name, got, exp, retired);
        retireErrs++;
        errCount++;
    endtask

    // sampled mid-cycle once everything has settled
    always @(negedge clk) begin
        if (rstN && !done) begin
            if (!resetSeen) begin
                resetSeen = 1'b1;   // first cycle out of reset
                if (fetchPc != '0 || retireValid || fetchReady) begin
                    $display("error reset state: fetchPc %h retireValid %h fetchReady %h",
                             fetchPc, retireValid, fetchReady);
                    errCount++;
                end
                $display("test reset state: %s", (errCount == 0) ? "ok" : "wrong");
            end
            if (icacheBusy || dcacheBusy) begin
                busyCycles++;
                if (retireValid || fetchReady) begin   // freeze must hold both low
                    $display("error busy freeze: retireValid %h fetchReady %h",
                             retireValid, fetchReady);
                    busyErrs++;
                    errCount++;
                end
            end
            if (retireValid) begin
                head = expQ.pop_front();
                idle = 0;
                if (retire.pc != head.pc)
                    reportMismatch("retire.pc", retire.pc, head.pc);
                if (retire.dest != head.dest)
                    reportMismatch("retire.dest", 32'(retire.dest), 32'(head.dest));
                if (retire.wrEn != head.wrEn)
                    reportMismatch("retire.wrEn", 32'(retire.wrEn), 32'(head.wrEn));
                retired++;
                if (!head.wrEn)
                    jumps++;                           // only jumps retire without a write
            end
            else begin
                idle++;
                if (idle > IdleLimit) begin
                    $display("timeout: no retire for %0d cycles with %0d still expected",
                             idle, expQ.size());
                    timedOut = 1'b1;
                end
            end
            if (expQ.size() == 0 || timedOut) begin
                $display("test retire stream: %0d retired, %0d jumps, %0d errors",
                         retired, jumps, retireErrs);
                $display("test busy freeze: %0d busy cycles, %0d errors", busyCycles, busyErrs);
                $display("checked %0d retires and %0d busy cycles, %0d errors in total",
                         retired, busyCycles, errCount);
                done = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/pipeTb.sv
`default_nettype none
`include "pipe_defines.svh"

module pipeTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ProgWords = 160;   // words 0..95 main code, 96.. trap handler
    localparam int TrapIdx   = 80;    // the only trap, pc 0x140
    localparam int RunLimit  = 5000;

    logic                  clk;
    logic                  rstN;
    logic [`PIPE_XLEN-1:0] fetchPc;
    logic                  fetchReady;
    logic                  fetchValid;
    logic [`PIPE_XLEN-1:0] fetchInstr;
    logic [`PIPE_XLEN-1:0] fetchRespPc;
    logic                  icacheBusy;
    logic                  dcacheBusy;
    logic                  retireValid;
    pipePkg::retireT       retire;
    logic                  done;
    logic                  timedOut;
    int                    errCount;
    int                    respDelay;    // idle cycles before the next response
    logic                  trapWindow;   // trap fetched, redirect not seen yet
    pipePkg::instrWordT    imem [ProgWords];

    pipeTop dut (
        .clk(clk), .rstN(rstN), .fetchPc(fetchPc), .fetchReady(fetchReady),
        .fetchValid(fetchValid), .fetchInstr(fetchInstr), .fetchRespPc(fetchRespPc),
        .icacheBusy(icacheBusy), .dcacheBusy(dcacheBusy),
        .retireValid(retireValid), .retire(retire)
    );

    pipeChecker chk (
        .clk(clk), .rstN(rstN), .fetchPc(fetchPc), .fetchReady(fetchReady),
        .icacheBusy(icacheBusy), .dcacheBusy(dcacheBusy), .retireValid(retireValid),
        .retire(retire), .done(done), .errCount(errCount), .timedOut(timedOut)
    );

    // low 16 bits are rd/shamt/funct or the immediate, depending on the view
    function automatic pipePkg::instrWordT makeWord(input logic [5:0] op, input logic [4:0] rs,
                                                    input logic [4:0] rt, input logic [15:0] low);
        return {op, rs, rt, low};
    endfunction

    // interpreter step, where control goes after the instruction at pc
    function automatic logic [`PIPE_XLEN-1:0] nextPc(input logic [`PIPE_XLEN-1:0] pc);
        pipePkg::instrWordT w;
        w = imem[pc >> 2];
        case (w.i.opcode)
            `OP_JUMP: return {14'd0, w.i.imm, 2'b00};   // word index target
            `OP_TRAP: return `TRAP_VECTOR;
            default:  return pc + 4;
        endcase
    endfunction

    // what the retire port must show for the instruction at pc
    function automatic pipePkg::retireT retireOf(input logic [`PIPE_XLEN-1:0] pc);
        pipePkg::instrWordT w;
        pipePkg::retireT    rec;
        w        = imem[pc >> 2];
        rec.pc   = pc;
        rec.dest = (w.i.opcode == `OP_LOAD) ? w.i.rt : w.r.rd;   // loads write rt
        rec.wrEn = 1'b1;
        if (w.i.opcode == `OP_JUMP) begin
            rec.dest = '0;
            rec.wrEn = 1'b0;
        end
        return rec;
    endfunction

    function automatic logic [`PIPE_XLEN-1:0] wordAt(input logic [`PIPE_XLEN-1:0] pc);
        if (pc < ProgWords * 4)
            return imem[pc >> 2];
        return {`OP_ALU, pc[27:2] ^ {22'd0, pc[31:28]}};   // filler past the program end
    endfunction

    function automatic logic nextBusy(input logic cur);
        return cur ? ($urandom % 2 == 0) : ($urandom % 12 == 0);   // short bursts
    endfunction

    // forward jumps only, so the interpreted path always ends
    task automatic buildProgram();
        int         i;
        int         pick;
        int         tgt;
        logic [4:0] d;
        i = 0;
        while (i < ProgWords) begin
            pick    = $urandom % 16;
            tgt     = i + 2 + $urandom % 4;
            d       = 5'($urandom % 31 + 1);   // never r0
            imem[i] = makeWord(`OP_ALU, 5'($urandom), 5'($urandom), 16'($urandom));
            if (i == TrapIdx) begin
                imem[i] = makeWord(`OP_TRAP, 5'd0, 5'd0, 16'd0);
            end
            else if (pick < 3 && i + 1 < ProgWords && i + 1 != TrapIdx) begin
                imem[i] = makeWord(`OP_LOAD, 5'($urandom), d, 16'($urandom));
                i++;
                imem[i] = makeWord(`OP_ALU, d, 5'($urandom), 16'($urandom)); // reads the load
            end
            else if (pick < 5) begin
                imem[i] = makeWord(`OP_MULDIV, 5'($urandom), 5'($urandom), 16'($urandom));
            end
            else if (pick < 7 && (tgt < TrapIdx || (i > TrapIdx && tgt < ProgWords))) begin
                imem[i] = makeWord(`OP_JUMP, 5'($urandom), 5'($urandom), 16'(tgt));
            end
            i++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fetch responder and cache busy stimulus, both change on the rising edge only
    always @(posedge clk) begin
        logic xfer;
        logic winNext;
        if (rstN) begin
            xfer = fetchValid && fetchReady && (fetchRespPc == fetchPc);
            if (fetchValid) begin
                if (xfer || fetchRespPc != fetchPc) begin
                    fetchValid <= 1'b0;            // taken, or stale after a redirect
                    respDelay  <= $urandom % 3;
                end
            end
            else if (respDelay > 0) begin
                respDelay <= respDelay - 1;
            end
            else begin
                fetchValid  <= 1'b1;
                fetchRespPc <= fetchPc;            // tag is the pc sampled here
                fetchInstr  <= wordAt(fetchPc);
            end
            winNext = trapWindow;
            if (xfer && fetchInstr[31:26] == `OP_TRAP)
                winNext = 1'b1;
            else if (fetchPc == `TRAP_VECTOR)
                winNext = 1'b0;                    // trap already taken
            trapWindow <= winNext;
            icacheBusy <= !winNext && nextBusy(icacheBusy);   // quiet while a trap is in flight
            dcacheBusy <= !winNext && nextBusy(dcacheBusy);
        end
    end

    initial begin
        logic [`PIPE_XLEN-1:0] pc;
        int                    cyc;
        void'($urandom(32'hd0d4));
        rstN        = 1'b0;
        fetchValid  = 1'b0;
        fetchInstr  = '0;
        fetchRespPc = '0;
        icacheBusy  = 1'b0;
        dcacheBusy  = 1'b0;
        respDelay   = 0;
        trapWindow  = 1'b0;
        buildProgram();
        pc = '0;
        while (pc < ProgWords * 4) begin
            if (imem[pc >> 2].i.opcode != `OP_TRAP)
                chk.addExpected(retireOf(pc));     // traps never retire
            pc = nextPc(pc);
        end
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        cyc = 0;
        while (!done && cyc < RunLimit) begin
            @(posedge clk);
            cyc++;
        end
        if (!done)
            $display("run did not finish within %0d cycles", RunLimit);
        if (done && !timedOut && errCount == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: common/pipePkg.sv
`default_nettype none
`include "pipe_defines.svh"

package pipePkg;

    // register-register view of an instruction word
    typedef struct packed {
        logic [`OPCODE_W-1:0]   opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } rTypeT;

    // immediate view, also used for loads and jumps
    typedef struct packed {
        logic [`OPCODE_W-1:0]   opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm;
    } iTypeT;

    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instrWordT;

    // one pipeline register slot
    typedef struct packed {
        logic                   valid;
        logic [`PIPE_XLEN-1:0]  pc;
        instrWordT              instr;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   wrEn;
    } stageRecT;

    typedef struct packed {
        logic [`PIPE_XLEN-1:0]  pc;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   wrEn;
    } retireT;

    // next pc source
    typedef enum logic [1:0] {
        REDIR_SEQ  = 2'd0,
        REDIR_JUMP = 2'd1,
        REDIR_TRAP = 2'd2
    } redirT;

    typedef struct packed {
        logic  pcWr;
        logic  idWr;
        logic  exeWr;
        logic  memWr;
        logic  wbWr;
        logic  idFlush;
        logic  exeFlush;
        logic  memFlush;
        logic  wbDisWr;
        redirT redirSel;
    } ctrlT;

endpackage

`default_nettype wire

// File: common/pipe_defines.svh
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// datapath widths
`define PIPE_XLEN       32      // pc and instruction word
`define REG_ADDR_W      5       // register specifier
`define OPCODE_W        6

// primary opcode field values
`define OP_ALU          6'h00
`define OP_LOAD         6'h23
`define OP_MULDIV       6'h1c
`define OP_JUMP         6'h02
`define OP_TRAP         6'h3f

`define TRAP_VECTOR     32'h0000_0180   // fetch restarts here after a trap
`define MULDIV_CYCLES   4               // cycles a mul/div occupies EXE

`endif

// File: control/hazardDetect.sv
`default_nettype none
`include "pipe_defines.svh"

module hazardDetect (
    input  pipePkg::stageRecT idRec,    // instruction being decoded
    input  pipePkg::stageRecT exeRec,   // instruction in EXE
    output logic              loadUse
);

    logic exeIsLoad;
    logic rsHit;
    logic rtHit;

    // r0 is never a real dependency
    assign exeIsLoad = exeRec.valid
                    && (exeRec.instr.r.opcode == `OP_LOAD)
                    && (exeRec.dest != '0);

    assign rsHit = (exeRec.dest == idRec.instr.r.rs);
    assign rtHit = (exeRec.dest == idRec.instr.r.rt); // conservative, any type

    assign loadUse = exeIsLoad && idRec.valid && (rsHit || rtHit);

endmodule

`default_nettype wire

// File: control/wrFlushControl.sv
`default_nettype none

module wrFlushControl (
    input  logic           clk,         // assertions only
    input  logic           rstN,
    input  logic           loadUse,     // load in EXE feeds ID
    input  logic           mdBusy,      // mul/div still working in EXE
    input  logic           idJump,      // immediate jump sitting in ID
    input  logic           memTrap,     // trap reached MEM
    input  logic           icacheBusy,
    input  logic           dcacheBusy,
    output pipePkg::ctrlT  ctrl
);

    logic anyBusy;
    logic jumpGo;

    assign anyBusy = icacheBusy || dcacheBusy;

    // a jump behind a busy mul/div waits in ID, else it would
    // be flushed out of IF/ID while ID/EXE is still held
    assign jumpGo = idJump && !mdBusy;

    always_comb begin
        // free flow by default
        ctrl.pcWr     = 1'b1;
        ctrl.idWr     = 1'b1;
        ctrl.exeWr    = 1'b1;
        ctrl.memWr    = 1'b1;
        ctrl.wbWr     = 1'b1;
        ctrl.idFlush  = 1'b0;
        ctrl.exeFlush = 1'b0;
        ctrl.memFlush = 1'b0;
        ctrl.wbDisWr  = 1'b0;
        ctrl.redirSel = pipePkg::REDIR_SEQ;

        if (memTrap) begin
            // kill everything younger than MEM, WB stays open
            ctrl.idFlush  = 1'b1;
            ctrl.exeFlush = 1'b1;
            ctrl.memFlush = 1'b1;
            ctrl.redirSel = pipePkg::REDIR_TRAP;
        end
        else if (anyBusy) begin
            ctrl.pcWr    = 1'b0;   // whole pipe frozen
            ctrl.idWr    = 1'b0;
            ctrl.exeWr   = 1'b0;
            ctrl.memWr   = 1'b0;
            ctrl.wbWr    = 1'b0;
            ctrl.wbDisWr = 1'b1;   // held WB record must not retire yet
        end
        else if (loadUse) begin
            ctrl.pcWr     = 1'b0;
            ctrl.idWr     = 1'b0;
            ctrl.exeFlush = 1'b1;  // bubble behind the load
        end
        else if (jumpGo) begin
            ctrl.idFlush  = 1'b1;  // no delay slot
            ctrl.redirSel = pipePkg::REDIR_JUMP;
        end
        else if (mdBusy) begin
            ctrl.pcWr  = 1'b0;
            ctrl.idWr  = 1'b0;
            ctrl.exeWr = 1'b0;     // EXE/MEM fills with bubbles meanwhile
        end
    end

    trapSelectsVector: assert property (@(posedge clk) disable iff (!rstN)
        memTrap |-> ctrl.pcWr && (ctrl.redirSel == pipePkg::REDIR_TRAP))
        else $error("trap in MEM without redirect to trap vector");

    busyFreezesPipe: assert property (@(posedge clk) disable iff (!rstN)
        anyBusy && !memTrap |->
            !(ctrl.pcWr || ctrl.idWr || ctrl.exeWr || ctrl.memWr || ctrl.wbWr)
            && ctrl.wbDisWr)
        else $error("stage write enable set while a cache is busy");

endmodule

`default_nettype wire

// File: filelist.f
+incdir+common
common/pipePkg.sv
control/wrFlushControl.sv
control/hazardDetect.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memWbStage.sv
verilog/pipeTop.sv
bench/pipeChecker.sv
bench/pipeTb.sv

// File: verilog/decodeStage.sv
`default_nettype none
`include "pipe_defines.svh"

module decodeStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  pipePkg::ctrlT         ctrl,
    input  pipePkg::stageRecT     ifRec,
    output pipePkg::stageRecT     idRec,       // decoded, to hazard check
    output logic                  idJump,
    output logic [`PIPE_XLEN-1:0] jumpTarget,
    output pipePkg::stageRecT     exeRecIn     // ID/EXE register
);

    logic [`OPCODE_W-1:0] opcode;

    assign opcode = ifRec.instr.r.opcode;   // same bits in either view

    always_comb begin
        idRec      = ifRec;
        idRec.dest = '0;
        idRec.wrEn = 1'b0;
        case (opcode)
            `OP_ALU, `OP_MULDIV: begin
                idRec.dest = ifRec.instr.r.rd;
                idRec.wrEn = 1'b1;
            end
            `OP_LOAD: begin
                idRec.dest = ifRec.instr.i.rt;  // loads write rt
                idRec.wrEn = 1'b1;
            end
            `OP_JUMP, `OP_TRAP: begin
                idRec.wrEn = 1'b0;   // no register result
            end
            default: begin
                idRec.wrEn = 1'b0;   // unknown opcode treated as nop
            end
        endcase
    end

    // jump resolved here, target is word index
    assign idJump     = ifRec.valid && (opcode == `OP_JUMP);
    assign jumpTarget = {{(`PIPE_XLEN-18){1'b0}}, ifRec.instr.i.imm, 2'b00};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exeRecIn <= '0;
        end
        else if (ctrl.exeFlush) begin
            exeRecIn <= '0;   // bubble
        end
        else if (ctrl.exeWr) begin
            exeRecIn <= idRec;
        end
    end

endmodule

`default_nettype wire

// File: verilog/executeStage.sv
`default_nettype none
`include "pipe_defines.svh"

module executeStage (
    input  logic              clk,
    input  logic              rstN,
    input  pipePkg::ctrlT     ctrl,
    input  pipePkg::stageRecT exeRecIn,   // ID/EXE register
    output pipePkg::stageRecT exeRec,     // what EXE hands on this cycle
    output logic              mdBusy,
    output pipePkg::stageRecT memRecIn    // EXE/MEM register
);

    localparam int CntW = $clog2(`MULDIV_CYCLES + 1);

    logic            isMulDiv;
    logic [CntW-1:0] mdCnt;   // cycles already spent in EXE

    assign isMulDiv = exeRecIn.valid && (exeRecIn.instr.r.opcode == `OP_MULDIV);
    assign mdBusy   = isMulDiv && (mdCnt != CntW'(`MULDIV_CYCLES - 1));

    // the unit keeps running through a cache freeze, then waits at the last count
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mdCnt <= '0;
        end
        else if (ctrl.exeFlush) begin
            mdCnt <= '0;          // EXE contents replaced
        end
        else if (mdBusy) begin
            mdCnt <= mdCnt + 1'b1;
        end
        else if (ctrl.exeWr) begin
            mdCnt <= '0;          // instruction leaves, next one starts fresh
        end
    end

    // unfinished mul/div looks like a bubble downstream
    always_comb begin
        exeRec = exeRecIn;
        if (mdBusy) begin
            exeRec.valid = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memRecIn <= '0;
        end
        else if (ctrl.memFlush) begin
            memRecIn <= '0;
        end
        else if (ctrl.memWr) begin
            memRecIn <= exeRec;
        end
    end

    mdCntBounded: assert property (@(posedge clk) disable iff (!rstN)
        mdCnt <= CntW'(`MULDIV_CYCLES))
        else $error("mul/div counter overran: %0d", mdCnt);

endmodule

`default_nettype wire

// File: verilog/fetchStage.sv
`default_nettype none
`include "pipe_defines.svh"

module fetchStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  pipePkg::ctrlT         ctrl,
    input  logic [`PIPE_XLEN-1:0] jumpTarget,
    input  logic                  fetchValid,
    input  logic [`PIPE_XLEN-1:0] fetchInstr,
    input  logic [`PIPE_XLEN-1:0] fetchRespPc,  // tag returned with the word
    output logic [`PIPE_XLEN-1:0] fetchPc,
    output logic                  fetchReady,
    output pipePkg::stageRecT     ifRec         // IF/ID register
);

    logic                  started;   // one quiet cycle out of reset
    logic                  xfer;
    logic [`PIPE_XLEN-1:0] nextPc;
    pipePkg::stageRecT     fetchRec;

    // only take a word when IF/ID can actually accept it
    assign fetchReady = started && ctrl.pcWr && ctrl.idWr && !ctrl.idFlush;
    assign xfer = fetchValid && fetchReady && (fetchRespPc == fetchPc); // stale tags ignored

    always_comb begin
        case (ctrl.redirSel)
            pipePkg::REDIR_JUMP: nextPc = jumpTarget;
            pipePkg::REDIR_TRAP: nextPc = `TRAP_VECTOR;
            default:             nextPc = fetchPc + `PIPE_XLEN'd4;
        endcase
    end

    always_comb begin
        fetchRec       = '0;
        fetchRec.valid = 1'b1;
        fetchRec.pc    = fetchPc;
        fetchRec.instr = fetchInstr; // dest filled in by decode
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            started <= 1'b0;
            fetchPc <= '0;
        end
        else begin
            started <= 1'b1;
            // redirects go at once, sequential only after a transfer
            if (ctrl.pcWr && (ctrl.redirSel != pipePkg::REDIR_SEQ || xfer)) begin
                fetchPc <= nextPc;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ifRec <= '0;
        end
        else if (ctrl.idFlush) begin
            ifRec <= '0;
        end
        else if (ctrl.idWr) begin
            ifRec <= xfer ? fetchRec : '0;   // bubble when nothing came back
        end
    end

    pcWordAligned: assert property (@(posedge clk) disable iff (!rstN)
        fetchPc[1:0] == 2'b00)
        else $error("fetch pc %h not word aligned", fetchPc);

endmodule

`default_nettype wire

// File: verilog/memWbStage.sv
`default_nettype none
`include "pipe_defines.svh"

module memWbStage (
    input  logic              clk,
    input  logic              rstN,
    input  pipePkg::ctrlT     ctrl,
    input  pipePkg::stageRecT memRecIn,   // EXE/MEM register
    output logic              memTrap,
    output logic              retireValid,
    output pipePkg::retireT   retire
);

    pipePkg::stageRecT wbRec;   // MEM/WB register

    // trap taken in MEM, younger stages are still speculative
    assign memTrap = memRecIn.valid && (memRecIn.instr.r.opcode == `OP_TRAP);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbRec <= '0;
        end
        else if (ctrl.wbWr) begin
            if (memTrap) begin
                wbRec <= '0;         // trap itself never retires
            end
            else begin
                wbRec <= memRecIn;
            end
        end
    end

    // held during a freeze, so it retires once the freeze lifts
    assign retireValid = wbRec.valid && !ctrl.wbDisWr;

    always_comb begin
        retire.pc   = wbRec.pc;
        retire.dest = wbRec.dest;
        retire.wrEn = wbRec.wrEn;
    end

endmodule

`default_nettype wire

// File: verilog/pipeTop.sv
`default_nettype none
`include "pipe_defines.svh"

module pipeTop (
    input  logic                  clk,
    input  logic                  rstN,
    output logic [`PIPE_XLEN-1:0] fetchPc,
    output logic                  fetchReady,
    input  logic                  fetchValid,
    input  logic [`PIPE_XLEN-1:0] fetchInstr,
    input  logic [`PIPE_XLEN-1:0] fetchRespPc,
    input  logic                  icacheBusy,
    input  logic                  dcacheBusy,
    output logic                  retireValid,
    output pipePkg::retireT       retire
);

    pipePkg::ctrlT         ctrl;
    pipePkg::stageRecT     ifRec;      // IF/ID
    pipePkg::stageRecT     idRec;      // decoded ID view
    pipePkg::stageRecT     exeRecIn;   // ID/EXE
    pipePkg::stageRecT     exeRec;
    pipePkg::stageRecT     memRecIn;   // EXE/MEM
    logic                  loadUse;
    logic                  mdBusy;
    logic                  idJump;
    logic                  memTrap;
    logic [`PIPE_XLEN-1:0] jumpTarget;

    wrFlushControl uCtrl (
        .clk(clk), .rstN(rstN), .loadUse(loadUse), .mdBusy(mdBusy),
        .idJump(idJump), .memTrap(memTrap), .icacheBusy(icacheBusy),
        .dcacheBusy(dcacheBusy), .ctrl(ctrl)
    );

    hazardDetect uHazard (.idRec(idRec), .exeRec(exeRec), .loadUse(loadUse));

    fetchStage uFetch (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .jumpTarget(jumpTarget),
        .fetchValid(fetchValid), .fetchInstr(fetchInstr), .fetchRespPc(fetchRespPc),
        .fetchPc(fetchPc), .fetchReady(fetchReady), .ifRec(ifRec)
    );

    decodeStage uDecode (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .ifRec(ifRec), .idRec(idRec),
        .idJump(idJump), .jumpTarget(jumpTarget), .exeRecIn(exeRecIn)
    );

    executeStage uExecute (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .exeRecIn(exeRecIn),
        .exeRec(exeRec), .mdBusy(mdBusy), .memRecIn(memRecIn)
    );

    memWbStage uMemWb (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .memRecIn(memRecIn),
        .memTrap(memTrap), .retireValid(retireValid), .retire(retire)
    );

endmodule

`default_nettype wire
